/* rtl/combPkg.sv */
// Vector combine shared definitions
`default_nettype none

package combPkg;

  // Lane geometry
  localparam int LANES = 8;
  // Lanes carried by one input beat
  localparam int HALF = 4;

  // Sequencer states, one pass per vector
  typedef enum logic [2:0] {
    IDLE,
    LOADHI,
    COMBINE,
    FOLD,
    WRITE
  } seqState_e;

  // Lane opcodes, all wrap modulo 2**WIDTH
  typedef enum logic [1:0] {
    ADD,
    SUB,
    XOR,
    AND
  } opcode_e;

endpackage

`default_nettype wire

/* rtl/seqCtrl.sv */
// Combine sequencer
`timescale 1ns/100ps
`default_nettype none

module seqCtrl #(
  parameter int OUT_CREDITS = 2
) (
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      inValid,
  input  combPkg::opcode_e          inOp,
  input  logic                      outCredit,
  output logic                      inCredit,
  output logic [combPkg::LANES-1:0] enA,
  output logic [combPkg::LANES-1:0] enB,
  output logic [combPkg::LANES-1:0] enC,
  output logic [combPkg::LANES-1:0] selMask,
  output logic                      loadSrc,
  output combPkg::opcode_e          op,
  output logic                      resultFire,
  output logic                      eom
);
  import combPkg::*;

  localparam int CW = $clog2(OUT_CREDITS + 1);
  localparam logic [LANES-1:0] LO_MASK = {{HALF{1'b0}}, {HALF{1'b1}}};
  localparam logic [LANES-1:0] HI_MASK = {{HALF{1'b1}}, {HALF{1'b0}}};

  seqState_e     state;
  seqState_e     nextState;
  logic [CW-1:0] creditCnt;
  logic          hasCredit;
  logic          grantDone;

  assign hasCredit  = (creditCnt != '0);
  assign eom        = (state == IDLE);
  // Write completes only when the consumer has room
  assign resultFire = (state == WRITE) && hasCredit;

  always_comb begin
    nextState = state;
    case (state)
      IDLE:    if (inValid) nextState = LOADHI;
      LOADHI:  if (inValid) nextState = COMBINE;
      COMBINE: nextState = FOLD;
      FOLD:    nextState = WRITE;
      WRITE:   if (hasCredit) nextState = IDLE;
      default: nextState = IDLE;
    endcase
  end

  // Per-state enable and select decode
  always_comb begin
    enA     = '0;
    enB     = '0;
    enC     = '0;
    selMask = '0;
    loadSrc = 1'b0;
    case (state)
      IDLE: begin
        loadSrc = 1'b1;
        if (inValid) begin
          enA = LO_MASK;
          enB = LO_MASK;
        end
      end
      LOADHI: begin
        loadSrc = 1'b1;
        if (inValid) begin
          enA = HI_MASK;
          enB = HI_MASK;
        end
      end
      // Straight select writes A op B back into A
      COMBINE: enA = '1;
      // Neighbour select writes A op A[i^1] into B
      FOLD: begin
        enB     = '1;
        selMask = '1;
      end
      WRITE: if (hasCredit) enC = '1;
      default: ;
    endcase
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= IDLE;
      op        <= ADD;
      creditCnt <= CW'(OUT_CREDITS);
      grantDone <= 1'b0;
      inCredit  <= 1'b0;
    end else begin
      state <= nextState;
      // Opcode rides with the low beat
      if (eom && inValid) op <= inOp;
      creditCnt <= creditCnt + CW'(outCredit) - CW'(resultFire);
      grantDone <= 1'b1;
      // One grant after reset and one per result sent
      inCredit  <= resultFire || !grantDone;
    end
  end

  default clocking cb @(posedge CLK); endclocking
  default disable iff (RST);

  assert property (state inside {IDLE, LOADHI, COMBINE, FOLD, WRITE});

  // Consumer never returns more than it was given
  assert property (creditCnt <= OUT_CREDITS);

  // No result goes out before a consumer credit comes back
  assert property (!hasCredit && !outCredit |=> !resultFire);

  // Sender only drives beats against a granted credit
  assert property (state inside {COMBINE, FOLD, WRITE} |-> !inValid);

endmodule

`default_nettype wire

/* rtl/operandBank.sv */
// Operand register bank
`timescale 1ns/100ps
`default_nettype none

module operandBank #(
  parameter int WIDTH = 8
) (
  input  logic                                    CLK,
  input  logic                                    RST,
  input  logic [combPkg::HALF-1:0][WIDTH-1:0]     inA,
  input  logic [combPkg::HALF-1:0][WIDTH-1:0]     inB,
  input  logic [combPkg::LANES-1:0][WIDTH-1:0]    aluOut,
  input  logic [combPkg::LANES-1:0]               enA,
  input  logic [combPkg::LANES-1:0]               enB,
  input  logic                                    loadSrc,
  output logic [combPkg::LANES-1:0][WIDTH-1:0]    regA,
  output logic [combPkg::LANES-1:0][WIDTH-1:0]    regB
);
  import combPkg::*;

  seqState_e impliedState;

  // Lane i takes beat lane i mod HALF, the enables pick the half
  always_ff @(posedge CLK) begin
    for (int i = 0; i < LANES; i++) begin
      if (enA[i]) begin
        regA[i] <= loadSrc ? inA[i % HALF] : aluOut[i];
      end
      if (enB[i]) begin
        regB[i] <= loadSrc ? inB[i % HALF] : aluOut[i];
      end
    end
  end

  // Phase as seen from the enable masks alone
  always_comb begin
    if (&enA) begin
      impliedState = COMBINE;
    end else if (&enB) begin
      impliedState = FOLD;
    end else begin
      impliedState = IDLE;
    end
  end

  default clocking cb @(posedge CLK); endclocking
  default disable iff (RST);

  // A and B never both rewritten in one pass
  assert property (!(&enA && &enB));

  // Combine result in A is always folded into B next
  assert property (impliedState == COMBINE |=> impliedState == FOLD);

  // ALU writes never come from an input beat
  assert property ((&enA || &enB) |-> !loadSrc);

endmodule

`default_nettype wire

/* rtl/laneAlu.sv */
// Lane ALU with pair routing
`timescale 1ns/100ps
`default_nettype none

module laneAlu #(
  parameter int WIDTH = 8
) (
  input  logic [combPkg::LANES-1:0][WIDTH-1:0] regA,
  input  logic [combPkg::LANES-1:0][WIDTH-1:0] regB,
  input  logic [combPkg::LANES-1:0]            selMask,
  input  combPkg::opcode_e                     op,
  output logic [combPkg::LANES-1:0][WIDTH-1:0] aluOut
);
  import combPkg::*;

  logic [LANES-1:0][WIDTH-1:0] neighbourA;
  logic [LANES-1:0][WIDTH-1:0] operandB;

  function automatic logic [WIDTH-1:0] laneOp(
    input opcode_e          code,
    input logic [WIDTH-1:0] a,
    input logic [WIDTH-1:0] b
  );
    logic [WIDTH-1:0] r;
    case (code)
      ADD:     r = a + b;
      SUB:     r = a - b;
      XOR:     r = a ^ b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  // Pair partner is the lane with bit 0 flipped
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      neighbourA[i] = regA[i ^ 1];
    end
  end

  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      operandB[i] = selMask[i] ? neighbourA[i] : regB[i];
      aluOut[i]   = laneOp(op, regA[i], operandB[i]);
    end
  end

endmodule

`default_nettype wire

/* rtl/resultBank.sv */
// Result register and output valid
`timescale 1ns/100ps
`default_nettype none

module resultBank #(
  parameter int WIDTH = 8
) (
  input  logic                                 CLK,
  input  logic                                 RST,
  input  logic [combPkg::LANES-1:0][WIDTH-1:0] regB,
  input  logic [combPkg::LANES-1:0]            enC,
  input  logic                                 resultFire,
  output logic [combPkg::LANES-1:0][WIDTH-1:0] outLanes,
  output logic                                 outValid
);
  import combPkg::*;

  logic [LANES-1:0][WIDTH-1:0] regC;

  always_ff @(posedge CLK) begin
    for (int i = 0; i < LANES; i++) begin
      if (enC[i]) begin
        regC[i] <= regB[i];
      end
    end
  end

  assign outLanes = regC;

  // Valid lines up with the freshly loaded C
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      outValid <= 1'b0;
    end else begin
      outValid <= resultFire;
    end
  end

  default clocking cb @(posedge CLK); endclocking
  default disable iff (RST);

  assert property (outValid |=> !outValid);

  // Every lane of C is refreshed when a result goes out
  assert property (resultFire |-> &enC);

  // No partial C update outside a sent result
  assert property (|enC |-> resultFire);

endmodule

`default_nettype wire

/* rtl/combTop.sv */
// Vector combine unit
`timescale 1ns/100ps
`default_nettype none

module combTop #(
  parameter int WIDTH       = 8,
  parameter int OUT_CREDITS = 2
) (
  input  logic                                 CLK,
  input  logic                                 RST,
  output logic                                 inCredit,
  input  logic                                 inValid,
  input  combPkg::opcode_e                     inOp,
  input  logic [combPkg::HALF-1:0][WIDTH-1:0]  inA,
  input  logic [combPkg::HALF-1:0][WIDTH-1:0]  inB,
  output logic                                 outValid,
  output logic [combPkg::LANES-1:0][WIDTH-1:0] outLanes,
  input  logic                                 outCredit
);
  import combPkg::*;

  logic [LANES-1:0]            enA;
  logic [LANES-1:0]            enB;
  logic [LANES-1:0]            enC;
  logic [LANES-1:0]            selMask;
  logic                        loadSrc;
  opcode_e                     op;
  logic                        resultFire;
  logic [LANES-1:0][WIDTH-1:0] regA;
  logic [LANES-1:0][WIDTH-1:0] regB;
  logic [LANES-1:0][WIDTH-1:0] aluOut;

  seqCtrl #(.OUT_CREDITS(OUT_CREDITS)) uSeq (
    .CLK(CLK), .RST(RST),
    .inValid(inValid), .inOp(inOp), .outCredit(outCredit),
    .inCredit(inCredit),
    .enA(enA), .enB(enB), .enC(enC), .selMask(selMask),
    .loadSrc(loadSrc), .op(op), .resultFire(resultFire),
    // Idle marker, the datapath has no use for it
    .eom()
  );

  operandBank #(.WIDTH(WIDTH)) uOperands (
    .CLK(CLK), .RST(RST),
    .inA(inA), .inB(inB), .aluOut(aluOut),
    .enA(enA), .enB(enB), .loadSrc(loadSrc),
    .regA(regA), .regB(regB)
  );

  laneAlu #(.WIDTH(WIDTH)) uAlu (
    .regA(regA), .regB(regB), .selMask(selMask), .op(op),
    .aluOut(aluOut)
  );

  resultBank #(.WIDTH(WIDTH)) uResult (
    .CLK(CLK), .RST(RST),
    .regB(regB), .enC(enC), .resultFire(resultFire),
    .outLanes(outLanes), .outValid(outValid)
  );

endmodule

`default_nettype wire

/* test/combTb.sv */
// Vector combine testbench
`timescale 1ns/100ps
`default_nettype none

module combTb;
  import combPkg::*;

  localparam int WIDTH = 8;
  localparam int OUT_CREDITS = 2;
  localparam int NVEC = 8;
  // Words per golden line: opcode, A lanes, B lanes, expected lanes
  localparam int WPL = 1 + 3 * LANES;

  typedef logic [LANES-1:0][WIDTH-1:0] laneVec_t;

  logic CLK = 1'b0;
  logic RST;
  logic inCredit;
  logic inValid;
  opcode_e inOp;
  logic [HALF-1:0][WIDTH-1:0] inA;
  logic [HALF-1:0][WIDTH-1:0] inB;
  logic outValid;
  laneVec_t outLanes;
  logic outCredit;

  logic [7:0] golden [0:NVEC*WPL-1];
  int cycleCount = 0;
  int grantCount = 0;
  int validCount = 0;
  int usedGrants = 0;
  int tbCredits = OUT_CREDITS;
  int laneErrors = 0;
  int opErrors = 0;
  int flowErrors = 0;
  int unsigned lcgState = 82;

  combTop #(.WIDTH(WIDTH), .OUT_CREDITS(OUT_CREDITS)) DUT (
    .CLK(CLK), .RST(RST),
    .inCredit(inCredit), .inValid(inValid), .inOp(inOp), .inA(inA), .inB(inB),
    .outValid(outValid), .outLanes(outLanes), .outCredit(outCredit)
  );

  always #10 CLK = ~CLK;

  // Pulse counters, read by the stimulus on falling edges
  always @(posedge CLK) begin
    cycleCount <= cycleCount + 1;
    if (inCredit) grantCount <= grantCount + 1;
    if (outValid) validCount <= validCount + 1;
  end

  function automatic int unsigned nextRand();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState >> 16;
  endfunction

  function automatic laneVec_t goldenLanes(int vec, int field);
    laneVec_t v;
    for (int i = 0; i < LANES; i++) v[i] = golden[vec*WPL + 1 + field*LANES + i];
    return v;
  endfunction

  // Combine lane-wise, then fold each lane with its pair partner
  function automatic laneVec_t combineRef(opcode_e code, laneVec_t a, laneVec_t b);
    laneVec_t mid;
    laneVec_t res;
    for (int i = 0; i < LANES; i++) begin
      case (code)
        ADD: mid[i] = a[i] + b[i];
        SUB: mid[i] = a[i] - b[i];
        XOR: mid[i] = a[i] ^ b[i];
        default: mid[i] = a[i] & b[i];
      endcase
    end
    for (int i = 0; i < LANES; i++) begin
      case (code)
        ADD: res[i] = mid[i] + mid[i ^ 1];
        SUB: res[i] = mid[i] - mid[i ^ 1];
        XOR: res[i] = mid[i] ^ mid[i ^ 1];
        default: res[i] = mid[i] & mid[i ^ 1];
      endcase
    end
    return res;
  endfunction

  task automatic checkLanes(string name, laneVec_t got, laneVec_t exp);
    if (got !== exp) begin
      laneErrors++;
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic checkOp(string name, opcode_e got, opcode_e exp);
    if (got !== exp) begin
      opErrors++;
      $display("[FAIL] %0t %s got %s expected %s", $time, name, got.name(), exp.name());
    end
  endtask

  task automatic checkFlag(string name, logic got, logic exp);
    if (got !== exp) begin
      flowErrors++;
      $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic checkCycles(string name, int got, int exp);
    if (got != exp) begin
      flowErrors++;
      $display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic waitGrant();
    int n = 0;
    while (grantCount <= usedGrants) begin
      @(negedge CLK);
      n++;
      if (n > 200) begin
        $display("Timed out waiting for an input credit");
        $display("RESULT: FAIL");
        $finish;
      end
    end
    usedGrants++;
  endtask

  task automatic waitValid();
    int n = 0;
    while (outValid !== 1'b1) begin
      @(negedge CLK);
      n++;
      if (n > 200) begin
        $display("Timed out waiting for a result");
        $display("RESULT: FAIL");
        $finish;
      end
    end
  endtask

  task automatic returnCredit();
    outCredit = 1'b1;
    tbCredits++;
    @(negedge CLK);
    outCredit = 1'b0;
  endtask

  // Two beats per credit, with a random idle gap between them
  task automatic sendVector(int vec, output int beat2Cycle);
    laneVec_t a;
    laneVec_t b;
    int gap;
    a = goldenLanes(vec, 0);
    b = goldenLanes(vec, 1);
    gap = nextRand() % 4;
    waitGrant();
    inValid = 1'b1;
    inOp = opcode_e'(golden[vec*WPL][1:0]);
    for (int i = 0; i < HALF; i++) begin
      inA[i] = a[i];
      inB[i] = b[i];
    end
    @(negedge CLK);
    inValid = 1'b0;
    inOp = ADD;
    repeat (gap) @(negedge CLK);
    inValid = 1'b1;
    for (int i = 0; i < HALF; i++) begin
      inA[i] = a[i + HALF];
      inB[i] = b[i + HALF];
    end
    beat2Cycle = cycleCount;
    @(negedge CLK);
    inValid = 1'b0;
  endtask

  initial begin
    int beat2Cycle;
    int hold;
    opcode_e code;
    laneVec_t expLanes;
    RST = 1'b1;
    inValid = 1'b0;
    inOp = ADD;
    inA = '0;
    inB = '0;
    outCredit = 1'b0;
    $readmemh("test/combGolden.txt", golden);
    repeat (16) @(negedge CLK);
    RST = 1'b0;

    // Exactly one grant and no result before any vector
    repeat (8) @(negedge CLK);
    checkCycles("inCredit pulses", grantCount, 1);
    checkCycles("outValid pulses", validCount, 0);

    for (int v = 0; v < NVEC; v++) begin
      code = opcode_e'(golden[v*WPL][1:0]);
      checkOp("golden opcode", code, opcode_e'(v / 2));
      expLanes = combineRef(code, goldenLanes(v, 0), goldenLanes(v, 1));
      checkLanes("golden expected", goldenLanes(v, 2), expLanes);
      sendVector(v, beat2Cycle);
      if (tbCredits == 0) begin
        // Consumer full, the result must wait
        hold = 10 + nextRand() % 8;
        for (int c = 0; c < hold; c++) begin
          checkFlag("outValid", outValid, 1'b0);
          @(negedge CLK);
        end
        returnCredit();
        waitValid();
      end else begin
        waitValid();
        checkCycles("outValid cycle", cycleCount, beat2Cycle + 4);
        checkFlag("inCredit", inCredit, 1'b1);
      end
      tbCredits--;
      checkLanes("outLanes", outLanes, expLanes);
      // First half returns credits at once, second half withholds them
      if (v < NVEC / 2) returnCredit();
      else @(negedge CLK);
    end

    $display("Errors: lanes %0d, opcodes %0d, flow %0d", laneErrors, opErrors, flowErrors);
    if (laneErrors + opErrors + flowErrors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* test/combGolden.txt */
// Columns: opcode (0 ADD, 1 SUB, 2 XOR, 3 AND), A lanes 0..7, B lanes 0..7,
// expected lanes 0..7, all hex bytes
0 01 02 03 04 05 06 07 08 10 10 10 10 10 10 10 10 23 23 27 27 2B 2B 2F 2F
0 F0 F0 80 80 FF 01 7F 7F 20 10 80 00 01 FF 01 00 10 10 80 80 00 00 FF FF
1 10 20 30 40 50 60 70 80 01 02 03 04 05 06 07 08 F1 0F F1 0F F1 0F F1 0F
1 00 00 FF 01 80 00 05 05 01 00 00 01 01 80 05 06 FF 01 FF 01 FF 01 01 FF
2 AA 55 F0 0F 12 34 56 78 FF FF 00 00 11 22 33 44 FF FF FF FF 15 15 59 59
2 01 02 03 04 05 06 07 08 01 02 03 04 05 06 07 08 00 00 00 00 00 00 00 00
3 FF FF F0 0F 3C 3F AA AE 0F F0 FF FF FF FF FF FF 00 00 00 00 3C 3C AA AA
3 12 34 56 78 9A BC DE F0 FF FF FF FF FF FF FF FF 10 10 50 50 98 98 D0 D0

/* vlog.f */
rtl/combPkg.sv
rtl/seqCtrl.sv
rtl/operandBank.sv
rtl/laneAlu.sv
rtl/resultBank.sv
rtl/combTop.sv
test/combTb.sv

/* Bender.yml */
package:
  name: comb_unit

sources:
  - rtl/combPkg.sv
  - rtl/seqCtrl.sv
  - rtl/operandBank.sv
  - rtl/laneAlu.sv
  - rtl/resultBank.sv
  - rtl/combTop.sv
  - target: simulation
    files:
      - test/combTb.sv
